/* Bender.yml */
package:
  name: motion_core

sources:
  - design/motion_pkg.sv
  - design/command_decoder.sv
  - design/move_queue.sv
  - design/dda_sequencer.sv
  - design/dda_axis.sv
  - design/motion_core_top.sv
  - target: test
    files:
      - test/motion_tb.sv

/* design/command_decoder.sv */
// Host word decoder, parses headers and move words and holds the enable and divisor registers
`timescale 1ns/1ps
`default_nettype none

module command_decoder
  import motion_pkg::*;
(
  input  wire                     CLK,
  input  wire                     resetn,
  input  wire [WORD_BITS-1:0]     word_data_received,
  input  wire                     word_received,
  output logic [WORD_BITS-1:0]    word_send_data,
  output move_t                   move_data,
  output logic                    move_write,
  output logic [NUM_MOTORS-1:0]   enable,
  output logic [DIVISOR_BITS-1:0] divisor
);

  logic                              word_received_q;  // Strobe from last cycle
  logic                              word_rise;
  logic [7:0]                        msg_header;       // Header of the move in progress
  logic [7:0]                        cmd;
  logic                              in_move;
  logic [$clog2(MOVE_WORDS+1)-1:0]   word_count;       // Words of the current move taken

  assign word_rise = word_received & ~word_received_q;
  assign cmd       = word_data_received[WORD_BITS-1 -: 8];
  assign in_move   = (msg_header == CMD_COORDINATED_STEP);

  // Control state and replies
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      msg_header      <= '0;
      word_count      <= '0;
      word_send_data  <= '0;
      move_write      <= 1'b0;
      enable          <= '0;
      divisor         <= DEFAULT_DIVISOR;
    end else begin
      word_received_q <= word_received;
      move_write      <= 1'b0;
      if (word_rise) begin
        word_send_data <= '0;  // Only two headers reply
        if (!in_move) begin
          msg_header <= cmd;
          word_count <= (cmd == CMD_COORDINATED_STEP) ? 1 : 0;
          case (cmd)
            CMD_MOTOR_ENABLE: begin
              enable <= word_data_received[NUM_MOTORS-1:0];
            end
            CMD_CLK_DIVISOR: begin
              divisor <= word_data_received[DIVISOR_BITS-1:0];
            end
            CMD_CHANNEL_INFO: begin
              word_send_data <= {{(WORD_BITS-32){1'b0}}, 8'(DURATION_BITS), 8'(DDA_BITS),
                                 8'd0, 8'(NUM_MOTORS)};  // No encoders in this build
            end
            CMD_API_VERSION: begin
              word_send_data <= {{(WORD_BITS-32){1'b0}}, VERSION_DEVEL, VERSION_MAJOR,
                                 VERSION_MINOR, VERSION_PATCH};
            end
            default: begin
            end
          endcase
        end else if (word_count == MOVE_WORDS - 1) begin
          // Last rate change word hands the record to the queue
          move_write <= 1'b1;
          msg_header <= '0;
          word_count <= '0;
        end else begin
          word_count <= word_count + 1'b1;
        end
      end
    end
  end

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!in_move) begin
        if (cmd == CMD_COORDINATED_STEP) begin
          move_data.dir <= word_data_received[NUM_MOTORS-1:0];  // Dir bits in header
        end
      end else if (word_count == 1) begin
        move_data.duration <= word_data_received[DURATION_BITS-1:0];
      end else begin
        // Rate and rate change alternate per axis
        for (int n = 0; n < NUM_MOTORS; n++) begin
          if (word_count == 2 * n + 2) begin
            move_data.axes[n].rate <= word_data_received[DDA_BITS-1:0];
          end
          if (word_count == 2 * n + 3) begin
            move_data.axes[n].rate_change <= word_data_received[DDA_BITS-1:0];
          end
        end
      end
    end
  end

  // Counter stays within one move
  a_word_count: assert property (@(posedge CLK) disable iff (resetn)
    word_count <= MOVE_WORDS);

endmodule

`default_nettype wire

/* design/dda_axis.sv */
// One stepper axis, rate and accumulator datapath with acceleration that emits step pulses
`timescale 1ns/1ps
`default_nettype none

module dda_axis
  import motion_pkg::*;
(
  input  wire             CLK,
  input  wire             resetn,
  input  wire             dda_tick,
  input  wire             load,
  input  wire             executing,
  input  wire axis_move_t params,
  output logic            step
);

  logic signed [DDA_BITS-1:0] rate;
  logic signed [DDA_BITS-1:0] rate_change;
  logic signed [DDA_BITS-1:0] accum;
  logic signed [DDA_BITS-1:0] accum_next;

  assign accum_next = accum + rate;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (load) begin
        accum       <= '0;
        rate        <= params.rate;
        rate_change <= params.rate_change;
      end else if (dda_tick && executing) begin
        rate <= rate + rate_change;  // Acceleration applied once per tick
        if (accum_next[DDA_BITS-1]) begin
          // Overflow into the top bit is one step
          step  <= 1'b1;
          accum <= {1'b0, accum_next[DDA_BITS-2:0]};
        end else begin
          accum <= accum_next;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/dda_sequencer.sv */
// DDA tick divider and move FSM, loads buffered moves and times them out
`timescale 1ns/1ps
`default_nettype none

module dda_sequencer
  import motion_pkg::*;
(
  input  wire                      CLK,
  input  wire                      resetn,
  input  wire [DIVISOR_BITS-1:0]   divisor,
  input  wire                      head_valid,
  input  wire [DURATION_BITS-1:0]  duration,
  output logic                     move_retire,
  output logic                     dda_tick,
  output logic                     load,
  output logic                     executing,
  output logic                     move_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_EXEC
  } seq_state_t;

  seq_state_t               state;
  logic [DIVISOR_BITS-1:0]  div_count;
  logic [DURATION_BITS-1:0] tick_count;  // Ticks spent on the current move
  logic                     move_end;

  // Divisor of 0 or 1 ticks every cycle
  assign dda_tick = ({1'b0, div_count} + 1'b1) >= {1'b0, divisor};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= '0;
    end else if (dda_tick || load) begin
      div_count <= '0;  // Each move starts on a fresh divisor period
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  assign load        = (state == ST_LOAD);
  assign move_end    = (state == ST_EXEC) && (tick_count == duration);
  assign executing   = (state == ST_EXEC) && !move_end;  // Low in the finishing cycle
  assign move_done   = move_end;
  assign move_retire = move_end;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= ST_IDLE;
      tick_count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (head_valid) begin
            state <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          tick_count <= '0;
          state      <= ST_EXEC;
        end
        ST_EXEC: begin
          if (move_end) begin
            state <= ST_IDLE;  // Queue retires the head on this edge
          end else if (dda_tick) begin
            tick_count <= tick_count + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // The running move keeps its record at the queue head
  a_head_held: assert property (@(posedge CLK) disable iff (resetn)
    (load || executing) |-> head_valid);

endmodule

`default_nettype wire

/* design/motion_core_top.sv */
// Top level of the three-axis motion controller, connects decoder, queue, sequencer and axes
`timescale 1ns/1ps
`default_nettype none

module motion_core_top
  import motion_pkg::*;
(
  input  wire                  CLK,
  input  wire                  resetn,
  input  wire [WORD_BITS-1:0]  word_data_received,
  input  wire                  word_received,
  output wire [WORD_BITS-1:0]  word_send_data,
  output wire                  buffer_dtr,
  output wire                  move_done,
  output motor_out_t           motors
);

  wire move_t                   move_data;
  wire move_t                   move_head;
  wire                          move_write;
  wire                          head_valid;
  wire                          move_retire;
  wire                          dda_tick;
  wire                          load;
  wire                          executing;
  wire [NUM_MOTORS-1:0]         enable;
  wire [NUM_MOTORS-1:0]         axis_step;
  wire [DIVISOR_BITS-1:0]       divisor;
  wire                          dir_valid;

  command_decoder decoder0 (
    .CLK, .resetn, .word_data_received, .word_received, .word_send_data,
    .move_data, .move_write, .enable, .divisor
  );

  move_queue queue0 (
    .CLK, .resetn, .move_data, .move_write, .move_head, .head_valid,
    .move_retire, .buffer_dtr
  );

  dda_sequencer seq0 (
    .CLK, .resetn, .divisor, .head_valid, .duration(move_head.duration),
    .move_retire, .dda_tick, .load, .executing, .move_done
  );

  for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_axis
    dda_axis axis (
      .CLK, .resetn, .dda_tick, .load, .executing,
      .params(move_head.axes[i]), .step(axis_step[i])
    );
  end

  // Last step of a move lands in the move_done cycle
  assign dir_valid = executing | move_done;
  assign motors = '{step: axis_step, dir: move_head.dir & {NUM_MOTORS{dir_valid}}, enable: enable};

endmodule

`default_nettype wire

/* design/motion_pkg.sv */
// Shared constants, command codes and record types, imported by every motion controller module
`default_nettype none

package motion_pkg;

  // Bus and datapath widths
  localparam int WORD_BITS     = 64;
  localparam int NUM_MOTORS    = 3;
  localparam int DDA_BITS      = 64;
  localparam int DURATION_BITS = 32;
  localparam int BUFFER_DEPTH  = 2;
  localparam int DIVISOR_BITS  = 8;

  localparam logic [DIVISOR_BITS-1:0] DEFAULT_DIVISOR = 8'd32;

  // Command codes, top byte of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0a;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h20;
  localparam logic [7:0] CMD_CHANNEL_INFO     = 8'hfd;
  localparam logic [7:0] CMD_API_VERSION      = 8'hfe;

  // Returned by the API version command
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd3;
  localparam logic [7:0] VERSION_PATCH = 8'd1;
  localparam logic [7:0] VERSION_DEVEL = 8'd0;

  // Header, duration, then rate and rate change per axis
  localparam int MOVE_WORDS = 2 + 2 * NUM_MOTORS;

  // Per-axis move parameters
  typedef struct packed {
    logic signed [DDA_BITS-1:0] rate;
    logic signed [DDA_BITS-1:0] rate_change;
  } axis_move_t;

  // One buffered coordinated move
  typedef struct packed {
    logic [NUM_MOTORS-1:0]    dir;
    logic [DURATION_BITS-1:0] duration;
    axis_move_t [NUM_MOTORS-1:0] axes;  // Index n is axis n
  } move_t;

  // Driver-facing motor signals
  typedef struct packed {
    logic [NUM_MOTORS-1:0] step;
    logic [NUM_MOTORS-1:0] dir;
    logic [NUM_MOTORS-1:0] enable;
  } motor_out_t;

endpackage

`default_nettype wire

/* design/move_queue.sv */
// Two-entry move buffer between the command decoder and the DDA sequencer
`timescale 1ns/1ps
`default_nettype none

module move_queue
  import motion_pkg::*;
(
  input  wire        CLK,
  input  wire        resetn,
  input  wire move_t move_data,
  input  wire        move_write,
  output move_t      move_head,
  output logic       head_valid,
  input  wire        move_retire,
  output logic       buffer_dtr
);

  localparam int IDX_BITS = $clog2(BUFFER_DEPTH);

  move_t                   slots [BUFFER_DEPTH];
  logic [IDX_BITS-1:0]     wr_idx;
  logic [IDX_BITS-1:0]     rd_idx;
  logic [BUFFER_DEPTH-1:0] full;
  logic                    do_write;

  assign do_write   = move_write & ~full[wr_idx];  // A write onto a full slot is lost
  assign move_head  = slots[rd_idx];
  assign head_valid = full[rd_idx];
  assign buffer_dtr = ~&full;  // Room for at least one more move

  always_ff @(posedge CLK) begin
    if (do_write) begin
      slots[wr_idx] <= move_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx <= '0;
      rd_idx <= '0;
      full   <= '0;
    end else begin
      if (do_write) begin
        full[wr_idx] <= 1'b1;
        wr_idx       <= IDX_BITS'((wr_idx + 1) % BUFFER_DEPTH);
      end
      // Retire never hits the slot being written, that one is empty
      if (move_retire && head_valid) begin
        full[rd_idx] <= 1'b0;
        rd_idx       <= IDX_BITS'((rd_idx + 1) % BUFFER_DEPTH);
      end
    end
  end

  // Host must wait for buffer_dtr before sending a move
  a_no_overwrite: assert property (@(posedge CLK) disable iff (resetn)
    move_write |-> !full[wr_idx]);

  // Sequencer only retires a move it has loaded
  a_retire_valid: assert property (@(posedge CLK) disable iff (resetn)
    move_retire |-> head_valid);

endmodule

`default_nettype wire

/* sim.f */
design/motion_pkg.sv
design/command_decoder.sv
design/move_queue.sv
design/dda_sequencer.sv
design/dda_axis.sv
design/motion_core_top.sv
test/motion_tb.sv

/* test/motion_tb.sv */
// Self-checking testbench that drives motion_core_top with host words and checks its outputs
`timescale 1ns/1ps
`default_nettype none

module motion_tb
  import motion_pkg::*;
();

  localparam int CLK_HALF     = 2;     // 4 ns period
  localparam int TIMEOUT      = 4000;  // Cycles allowed per wait
  localparam int SPAN_TOL     = 3;
  localparam int TEST_DIVISOR = 8;

  // Expected outcome of one buffered move
  typedef struct packed {
    logic [NUM_MOTORS-1:0]       dir;
    logic [NUM_MOTORS-1:0][31:0] steps;
  } move_expect_t;

  logic                 CLK;
  logic                 resetn;
  logic [WORD_BITS-1:0] word_data_received;
  logic                 word_received;
  wire  [WORD_BITS-1:0] word_send_data;
  wire                  buffer_dtr;
  wire                  move_done;
  motor_out_t           motors;

  int           seed;
  int           errors;
  int           tests_run;
  int           tests_failed;
  bit           timed_out;
  int           done_count;    // move_done pulses seen since reset
  int           span_cycles;
  int           last_span;     // Cycles from first dir-valid cycle to move_done
  int           cur_steps [NUM_MOTORS];
  move_expect_t expect_q [$];
  move_expect_t done_exp;

  motion_core_top dut0 (
    .CLK, .resetn, .word_data_received, .word_received, .word_send_data,
    .buffer_dtr, .move_done, .motors
  );

  always #CLK_HALF CLK = ~CLK;

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("ERR %s: got 0x%h expected 0x%h", sig, got, want);
    errors++;
  endtask

  task automatic flag_failure(input string what);
    $display("%s", what);
    errors++;
  endtask

  // Expected step count of one axis over a move
  function automatic int step_model(input logic [DDA_BITS-1:0] rate,
                                    input logic [DDA_BITS-1:0] rate_change, input int dur);
    logic [DDA_BITS-1:0] acc;
    logic [DDA_BITS-1:0] r;
    logic [DDA_BITS-1:0] nxt;
    int                  steps;
    acc = '0;
    r = rate;
    steps = 0;
    for (int k = 0; k < dur; k++) begin
      nxt = acc + r;
      r = r + rate_change;
      if (nxt[DDA_BITS-1]) begin
        steps++;
        acc = {1'b0, nxt[DDA_BITS-2:0]};  // Top bit spent on the step
      end else begin
        acc = nxt;
      end
    end
    return steps;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // At least one bit set so a stuck-low output shows up
  function automatic logic [NUM_MOTORS-1:0] pick_nonzero_bits();
    logic [NUM_MOTORS-1:0] bits;
    bits = NUM_MOTORS'($random(seed));
    while (bits == '0) begin
      bits = NUM_MOTORS'($random(seed));
    end
    return bits;
  endfunction

  // Step counter and move checker
  always @(posedge CLK) begin
    if (resetn) begin
      for (int i = 0; i < NUM_MOTORS; i++) cur_steps[i] = 0;
      span_cycles = 0;
      done_count = 0;
    end else begin
      for (int i = 0; i < NUM_MOTORS; i++) begin
        if (motors.step[i]) cur_steps[i]++;
      end
      if (motors.dir != '0) span_cycles++;
      if (expect_q.size() != 0 && (motors.dir != '0 || move_done) &&
          motors.dir !== expect_q[0].dir) begin
        report_mismatch("motors.dir", motors.dir, expect_q[0].dir);
      end
      if (move_done) begin
        done_count++;
        if (expect_q.size() == 0) begin
          flag_failure("move_done pulsed with no move outstanding");
        end else begin
          done_exp = expect_q.pop_front();
          for (int i = 0; i < NUM_MOTORS; i++) begin
            if (cur_steps[i] != done_exp.steps[i])
              report_mismatch($sformatf("motors.step[%0d] count", i), cur_steps[i],
                              done_exp.steps[i]);
          end
        end
        last_span = span_cycles - 1;
        span_cycles = 0;
        for (int i = 0; i < NUM_MOTORS; i++) cur_steps[i] = 0;
      end
    end
  end

  task automatic send_word(input logic [WORD_BITS-1:0] data, output logic [WORD_BITS-1:0] reply);
    @(posedge CLK);
    #1;
    word_data_received = data;
    word_received = 1'b1;
    repeat (3) @(posedge CLK);
    #1;
    word_received = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    reply = word_send_data;
  endtask

  // Random rates with the model result queued before the words go out
  task automatic send_move(input logic [NUM_MOTORS-1:0] dir, input int dur);
    logic [WORD_BITS-1:0] reply;
    logic [DDA_BITS-1:0]  rate [NUM_MOTORS];
    logic [DDA_BITS-1:0]  rchg [NUM_MOTORS];
    move_expect_t         exp;
    int                   n;
    n = 0;
    while (!buffer_dtr && n < TIMEOUT) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (!buffer_dtr) begin
      flag_failure("Timeout: move buffer never had room for a new move");
      timed_out = 1'b1;
    end else begin
      exp.dir = dir;
      for (int i = 0; i < NUM_MOTORS; i++) begin
        rate[i] = random_word() & 64'h3fff_ffff_ffff_ffff;
        rchg[i] = random_word() & 64'h00ff_ffff_ffff_ffff;  // Small next to the rate
        exp.steps[i] = step_model(rate[i], rchg[i], dur);
      end
      expect_q.push_back(exp);
      send_word({CMD_COORDINATED_STEP, {(WORD_BITS-8-NUM_MOTORS){1'b0}}, dir}, reply);
      send_word({{(WORD_BITS-DURATION_BITS){1'b0}}, DURATION_BITS'(dur)}, reply);
      for (int i = 0; i < NUM_MOTORS; i++) begin
        send_word(rate[i], reply);
        send_word(rchg[i], reply);
      end
    end
  endtask

  task automatic wait_for_moves(input int target);
    int n;
    n = 0;
    while (done_count < target && n < TIMEOUT) begin
      @(posedge CLK);
      #2;
      n++;
    end
    if (done_count < target) begin
      flag_failure($sformatf("Timeout: move %0d never signalled move_done", target));
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    end
  endtask

  task automatic reset_and_id_replies();
    logic [WORD_BITS-1:0] reply;
    logic [WORD_BITS-1:0] want;
    int                   err0;
    err0 = errors;
    if (buffer_dtr !== 1'b1) report_mismatch("buffer_dtr", buffer_dtr, 1);
    if (motors.enable !== '0) report_mismatch("motors.enable", motors.enable, 0);
    if (motors.step !== '0) report_mismatch("motors.step", motors.step, 0);
    if (word_send_data !== '0) report_mismatch("word_send_data", word_send_data, 0);
    send_word({CMD_API_VERSION, {(WORD_BITS-8){1'b0}}}, reply);
    want = {32'h0, VERSION_DEVEL, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    if (reply !== want) report_mismatch("word_send_data", reply, want);
    send_word({CMD_CHANNEL_INFO, {(WORD_BITS-8){1'b0}}}, reply);
    want = {32'h0, 8'(DURATION_BITS), 8'(DDA_BITS), 8'h00, 8'(NUM_MOTORS)};  // No encoders
    if (reply !== want) report_mismatch("word_send_data", reply, want);
    report_test("reset state and id replies", err0);
  endtask

  task automatic motor_enable_bits();
    logic [WORD_BITS-1:0]  reply;
    logic [NUM_MOTORS-1:0] bits;
    int                    err0;
    err0 = errors;
    bits = pick_nonzero_bits();
    send_word({CMD_MOTOR_ENABLE, {(WORD_BITS-8-NUM_MOTORS){1'b0}}, bits}, reply);
    if (reply !== '0) report_mismatch("word_send_data", reply, 0);
    if (motors.enable !== bits) report_mismatch("motors.enable", motors.enable, bits);
    report_test("motor enable", err0);
  endtask

  task automatic single_move_steps();
    int err0;
    int base;
    err0 = errors;
    base = done_count;
    send_move(pick_nonzero_bits(), 20);
    if (!timed_out) wait_for_moves(base + 1);
    if (!timed_out) begin
      repeat (200) @(posedge CLK);  // Window for a stray second pulse
      #2;
      if (done_count != base + 1) report_mismatch("move_done pulses", done_count - base, 1);
    end
    report_test("single coordinated move", err0);
  endtask

  task automatic back_to_back_moves();
    int err0;
    int base;
    err0 = errors;
    base = done_count;
    send_move(NUM_MOTORS'($random(seed)), 20);
    if (!timed_out) send_move(NUM_MOTORS'($random(seed)), 20);
    if (!timed_out) begin
      if (buffer_dtr !== 1'b0) report_mismatch("buffer_dtr", buffer_dtr, 0);  // Both slots full
      wait_for_moves(base + 2);
    end
    if (!timed_out) begin
      @(posedge CLK);
      #2;
      if (done_count != base + 2) report_mismatch("move_done pulses", done_count - base, 2);
      if (buffer_dtr !== 1'b1) report_mismatch("buffer_dtr", buffer_dtr, 1);
    end
    report_test("two buffered moves", err0);
  endtask

  task automatic divided_tick_timing();
    logic [WORD_BITS-1:0] reply;
    int                   err0;
    int                   base;
    int                   lo;
    int                   hi;
    err0 = errors;
    send_word({CMD_CLK_DIVISOR, {(WORD_BITS-8-DIVISOR_BITS){1'b0}},
               DIVISOR_BITS'(TEST_DIVISOR)}, reply);
    base = done_count;
    send_move('1, 10);  // All dir bits set so the move window is visible
    if (!timed_out) wait_for_moves(base + 1);
    // Ten divided ticks plus up to one divisor period of slack
    lo = 10 * TEST_DIVISOR - SPAN_TOL;
    hi = 11 * TEST_DIVISOR + SPAN_TOL;
    if (!timed_out && (last_span < lo || last_span > hi))
      flag_failure($sformatf("Move with divisor %0d lasted %0d cycles, expected %0d to %0d",
                             TEST_DIVISOR, last_span, lo, hi));
    report_test("divided tick timing", err0);
  endtask

  initial begin
    CLK = 1'b0;
    resetn = 1'b1;
    word_data_received = '0;
    word_received = 1'b0;
    seed = 48;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    last_span = 0;
    repeat (2) @(posedge CLK);
    #1;
    resetn = 1'b0;
    @(posedge CLK);
    #1;
    reset_and_id_replies();
    if (!timed_out) motor_enable_bits();
    if (!timed_out) single_move_steps();
    if (!timed_out) back_to_back_moves();
    if (!timed_out) divided_tick_timing();
    $display("tests run %0d, tests with errors %0d, errors %0d%s", tests_run, tests_failed,
             errors, timed_out ? ", stopped after a timeout" : "");
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
